// File: tb.f
+incdir+src
src/mm_pkg.sv
src/fetch_fsm.sv
src/ip_counter.sv
src/cmd_word_reg.sv
src/operand_file.sv
src/bus_port.sv
src/mem_manager.sv
testbench/mm_assert.sv
testbench/tb_mem_manager.sv

// File: Makefile
TOP := tb_mem_manager

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "^>>> PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_mem_manager.sv
`timescale 1ns/1ps
`include "mm_consts.svh"

module tb_mem_manager;
  import mm_pkg::*;

  localparam int    N_CMDS     = 40;
  localparam int    CMD_CYCLES = 60;
  localparam int    CLK_NS     = 4;
  localparam addr_t BASE       = 32'h0000_00f0;

  // one bus transfer as seen on the port
  typedef struct packed {
    logic  wr;
    addr_t addr;
    data_t data;
  } xfer_t;

  logic        clk;
  logic        rst;
  logic        start;
  addr_t       start_addr;
  addr_t       base_addr;
  data_t       data_in    = '0;
  logic        read_dn    = 1'b0;
  logic        write_dn   = 1'b0;
  data_t       alu_result = '0;
  logic        alu_done   = 1'b0;
  bus_req_t    bus;
  cmd_fields_t cmd;
  data_t       src1;
  data_t       src0;
  logic        operands_valid;
  logic        done;

  integer      seed;
  int          errors;
  int          checks;
  int          mem_wait = -1;
  int          alu_wait = -1;
  int          n;
  int          i;
  data_t       mem [256];
  data_t       exp_mem [256];
  xfer_t       trace_q [$];
  xfer_t       exp_q [$];
  cmd_fields_t exp_cmd;
  data_t       exp_src1;
  data_t       exp_src0;

  mem_manager i_dut (
    .clk(clk), .rst(rst), .start(start), .start_addr(start_addr), .base_addr(base_addr),
    .data_in(data_in), .read_dn(read_dn), .write_dn(write_dn), .bus(bus), .cmd(cmd),
    .src1(src1), .src0(src0), .operands_valid(operands_valid),
    .alu_result(alu_result), .alu_done(alu_done), .done(done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  function automatic xfer_t make_xfer(input logic wr, input addr_t addr, input data_t data);
    xfer_t x;
    x.wr   = wr;
    x.addr = addr;
    x.data = data;
    return x;
  endfunction

  task automatic show_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    errors++;
    $display("MISMATCH %s got=%h expected=%h", name, got, want);
  endtask

  // memory model answers each strobe after 0 to 3 extra cycles
  always @(posedge clk) begin
    read_dn  <= 1'b0;
    write_dn <= 1'b0;
    // skip the edge that closes our own pulse
    if (!rst && !read_dn && !write_dn && (bus.read_q || bus.write_q)) begin
      if (mem_wait < 0) mem_wait = $random(seed) & 3;
      if (mem_wait == 0) begin
        if (bus.read_q) begin
          data_in <= mem[bus.addr[7:0]];
          read_dn <= 1'b1;
          trace_q.push_back(make_xfer(1'b0, bus.addr, mem[bus.addr[7:0]]));
        end else begin
          mem[bus.addr[7:0]] = bus.wdata;
          write_dn <= 1'b1;
          trace_q.push_back(make_xfer(1'b1, bus.addr, bus.wdata));
        end
        mem_wait = -1;
      end else begin
        mem_wait = mem_wait - 1;
      end
    end
  end

  // alu model adds the operands after a random delay
  always @(posedge clk) begin
    alu_done <= 1'b0;
    if (!rst && operands_valid && !alu_done) begin
      if (alu_wait < 0) begin
        // first exec cycle has operands and decode settled
        checks += 3;
        assert (cmd == exp_cmd) else show_mismatch("cmd", 32'(cmd), 32'(exp_cmd));
        assert (src1 == exp_src1) else show_mismatch("src1", src1, exp_src1);
        assert (src0 == exp_src0) else show_mismatch("src0", src0, exp_src0);
        alu_wait = $random(seed) & 3;
      end
      if (alu_wait == 0) begin
        alu_result <= src1 + src0;
        alu_done   <= 1'b1;
        alu_wait = -1;
      end else begin
        alu_wait = alu_wait - 1;
      end
    end
  end

  // random command at ip over freshly filled registers
  // then the expected bus trace for it
  task automatic setup_command(input addr_t ip);
    regnum_t s1n;
    regnum_t s0n;
    regnum_t dn;
    logic    s1p;
    logic    s0p;
    logic    dp;
    flag_t   s1f;
    flag_t   s0f;
    opcode_t op;
    data_t   word;
    data_t   v1;
    data_t   v0;
    data_t   op1;
    data_t   op0;
    addr_t   a1;
    addr_t   a0;
    addr_t   ad;
    int      r;
    s1n = regnum_t'($random(seed));
    s0n = regnum_t'($random(seed));
    dn  = regnum_t'($random(seed));
    {dp, s0p, s1p} = 3'($random(seed));
    s1f = flag_t'($random(seed));
    s0f = flag_t'($random(seed));
    op  = opcode_t'($random(seed));
    // register contents point into the data area 0x40..0x7f
    for (r = 0; r < 16; r++) mem[BASE[7:0] + 8'(r)] = 32'h40 | ($random(seed) & 32'h3f);
    word = '0;
    word[`MM_S1_NUM_LSB +: `MM_REGNUM_W] = s1n;
    word[`MM_S0_NUM_LSB +: `MM_REGNUM_W] = s0n;
    word[`MM_D_NUM_LSB +: `MM_REGNUM_W]  = dn;
    word[`MM_S1_PTR_BIT] = s1p;
    word[`MM_S0_PTR_BIT] = s0p;
    word[`MM_D_PTR_BIT]  = dp;
    word[`MM_S1_FLAG_LSB +: `MM_FLAG_W] = s1f;
    word[`MM_S0_FLAG_LSB +: `MM_FLAG_W] = s0f;
    word[`MM_OPCODE_LSB +: `MM_OPCODE_W] = op;
    mem[ip[7:0]] = word;
    exp_cmd = {op, s0f, s1f, dp, s0p, s1p, dn, s0n, s1n};
    // replay the command on a private copy
    exp_mem = mem;
    exp_q.delete();
    trace_q.delete();
    exp_q.push_back(make_xfer(1'b0, ip, word));
    a1  = BASE + addr_t'(s1n);
    v1  = exp_mem[a1[7:0]];
    op1 = v1;
    exp_q.push_back(make_xfer(1'b0, a1, v1));
    if (s1p) begin
      op1 = exp_mem[v1[7:0]];
      exp_q.push_back(make_xfer(1'b0, v1, op1));
    end
    a0  = BASE + addr_t'(s0n);
    v0  = exp_mem[a0[7:0]];
    op0 = v0;
    exp_q.push_back(make_xfer(1'b0, a0, v0));
    if (s0p) begin
      op0 = exp_mem[v0[7:0]];
      exp_q.push_back(make_xfer(1'b0, v0, op0));
    end
    exp_src1 = op1;
    exp_src0 = op0;
    ad = BASE + addr_t'(dn);
    if (dp) begin
      exp_q.push_back(make_xfer(1'b0, ad, exp_mem[ad[7:0]]));
      ad = exp_mem[ad[7:0]];
    end
    exp_q.push_back(make_xfer(1'b1, ad, op1 + op0));
    // post-modify uses the values read before the result write
    if ((s1f == `MM_FLAG_INC) || (s1f == `MM_FLAG_DEC)) begin
      v1 = (s1f == `MM_FLAG_INC) ? v1 + data_t'(1) : v1 - data_t'(1);
      exp_q.push_back(make_xfer(1'b1, a1, v1));
    end
    if ((s0f == `MM_FLAG_INC) || (s0f == `MM_FLAG_DEC)) begin
      v0 = (s0f == `MM_FLAG_INC) ? v0 + data_t'(1) : v0 - data_t'(1);
      exp_q.push_back(make_xfer(1'b1, a0, v0));
    end
  endtask

  task automatic compare_trace(input int num);
    int    k;
    xfer_t got;
    xfer_t want;
    checks++;
    assert (trace_q.size() == exp_q.size()) else begin
      errors++;
      $display("command %0d made %0d bus transfers instead of %0d",
               num, trace_q.size(), exp_q.size());
    end
    for (k = 0; (k < exp_q.size()) && (k < trace_q.size()); k++) begin
      got  = trace_q[k];
      want = exp_q[k];
      checks += 3;
      assert (got.wr == want.wr) else begin
        errors++;
        $display("command %0d transfer %0d went in the wrong direction", num, k);
      end
      assert (got.addr == want.addr) else show_mismatch("bus.addr", got.addr, want.addr);
      assert (got.data == want.data)
        else show_mismatch(want.wr ? "bus.wdata" : "data_in", got.data, want.data);
    end
  endtask

  initial begin
    seed       = 32'h2d8f;
    errors     = 0;
    checks     = 0;
    rst        = 1'b1;
    start      = 1'b0;
    start_addr = '0;
    base_addr  = BASE;
    for (i = 0; i < 256; i++) mem[i[7:0]] = $random(seed);
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (n = 0; n < N_CMDS; n++) begin
      @(posedge clk);
      setup_command(addr_t'(n));
      start      <= 1'b1;
      start_addr <= addr_t'(n);
      @(posedge clk);
      start <= 1'b0;
      @(posedge clk);
      while (!done) @(posedge clk);
      compare_trace(n);
    end
    @(posedge clk);
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, i_dut.i_chk.fail_cnt);
    if ((errors == 0) && (i_dut.i_chk.fail_cnt == 0)) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // watchdog sized from the per-command cycle budget
  initial begin
    #(N_CMDS * CMD_CYCLES * CLK_NS);
    $display("timeout: the commands did not complete in time");
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: testbench/mm_assert.sv
`timescale 1ns/1ps

module mm_assert (
  input logic              clk,
  input logic              rst,
  input mm_pkg::bus_req_t  bus,
  input logic              read_dn,
  input logic              write_dn,
  input logic              operands_valid,
  input logic              done
);

  // running count of failed properties
  int unsigned fail_cnt = 0;

  // one strobe at a time
  a_one_strobe: assert property (@(posedge clk) disable iff (rst)
    !(bus.read_q && bus.write_q))
    else begin
      fail_cnt++;
      $error("read_q and write_q are high together");
    end

  // read request held with a steady address until read_dn
  a_read_hold: assert property (@(posedge clk) disable iff (rst)
    (bus.read_q && !read_dn) |=> (bus.read_q && $stable(bus.addr)))
    else begin
      fail_cnt++;
      $error("read request dropped or moved before read_dn");
    end

  // write request keeps address and data steady until write_dn
  a_write_hold: assert property (@(posedge clk) disable iff (rst)
    (bus.write_q && !write_dn) |=>
      (bus.write_q && $stable(bus.addr) && $stable(bus.wdata)))
    else begin
      fail_cnt++;
      $error("write request dropped or changed before write_dn");
    end

  // quiet outputs after reset
  a_reset_idle: assert property (@(posedge clk)
    rst |=> (!bus.read_q && !bus.write_q && !operands_valid && !done))
    else begin
      fail_cnt++;
      $error("control outputs active after reset");
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    done |=> !done)
    else begin
      fail_cnt++;
      $error("done held longer than one cycle");
    end

endmodule

bind mem_manager mm_assert i_chk (
  .clk(clk), .rst(rst), .bus(bus), .read_dn(read_dn), .write_dn(write_dn),
  .operands_valid(operands_valid), .done(done)
);

// File: src/mem_manager.sv
`timescale 1ns/1ps

module mem_manager (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  mm_pkg::addr_t       start_addr,
  input  mm_pkg::addr_t       base_addr,
  input  mm_pkg::data_t       data_in,
  input  logic                read_dn,
  input  logic                write_dn,
  output mm_pkg::bus_req_t    bus,
  output mm_pkg::cmd_fields_t cmd,
  output mm_pkg::data_t       src1,
  output mm_pkg::data_t       src0,
  output logic                operands_valid,
  input  mm_pkg::data_t       alu_result,
  input  logic                alu_done,
  output logic                done
);
  import mm_pkg::*;

  fsm_state_t state;
  addr_t      ip;
  data_t      s1_wb;
  data_t      s0_wb;
  data_t      dst_ptr;
  data_t      result;

  // sequencing
  fetch_fsm i_fsm (
    .clk(clk), .rst(rst), .start(start), .read_dn(read_dn), .write_dn(write_dn),
    .alu_done(alu_done), .cmd(cmd), .state(state),
    .operands_valid(operands_valid), .done(done)
  );

  ip_counter i_ip (
    .clk(clk), .rst(rst), .start(start), .state(state), .read_dn(read_dn),
    .start_addr(start_addr), .ip(ip)
  );

  cmd_word_reg i_cmd (
    .clk(clk), .rst(rst), .read_dn(read_dn), .state(state),
    .data_in(data_in), .cmd(cmd)
  );

  // operand and result storage
  operand_file i_ops (
    .clk(clk), .rst(rst), .read_dn(read_dn), .alu_done(alu_done), .state(state),
    .cmd(cmd), .data_in(data_in), .alu_result(alu_result), .src1(src1), .src0(src0),
    .s1_wb(s1_wb), .s0_wb(s0_wb), .dst_ptr(dst_ptr), .result(result)
  );

  // bus request forming
  bus_port i_bus (
    .state(state), .cmd(cmd), .ip(ip), .base_addr(base_addr), .src1(src1),
    .src0(src0), .s1_wb(s1_wb), .s0_wb(s0_wb), .dst_ptr(dst_ptr),
    .result(result), .bus(bus)
  );

endmodule

// File: src/bus_port.sv
`timescale 1ns/1ps

module bus_port (
  input  mm_pkg::fsm_state_t  state,
  input  mm_pkg::cmd_fields_t cmd,
  input  mm_pkg::addr_t       ip,
  input  mm_pkg::addr_t       base_addr,
  input  mm_pkg::data_t       src1,
  input  mm_pkg::data_t       src0,
  input  mm_pkg::data_t       s1_wb,
  input  mm_pkg::data_t       s0_wb,
  input  mm_pkg::data_t       dst_ptr,
  input  mm_pkg::data_t       result,
  output mm_pkg::bus_req_t    bus
);
  import mm_pkg::*;

  // register addresses in memory
  addr_t s1_addr;
  addr_t s0_addr;
  addr_t d_addr;

  assign s1_addr = base_addr + addr_t'(cmd.s1_num);
  assign s0_addr = base_addr + addr_t'(cmd.s0_num);
  assign d_addr  = base_addr + addr_t'(cmd.d_num);

  always_comb begin
    bus = '0;
    case (state)
      ST_FETCH: begin
        bus.addr   = ip;
        bus.read_q = 1'b1;
      end
      ST_S1_REG: begin
        bus.addr   = s1_addr;
        bus.read_q = 1'b1;
      end
      ST_S1_PTR: begin
        // src1 still holds the register value here
        bus.addr   = addr_t'(src1);
        bus.read_q = 1'b1;
      end
      ST_S0_REG: begin
        bus.addr   = s0_addr;
        bus.read_q = 1'b1;
      end
      ST_S0_PTR: begin
        bus.addr   = addr_t'(src0);
        bus.read_q = 1'b1;
      end
      ST_D_REG: begin
        bus.addr   = d_addr;
        bus.read_q = 1'b1;
      end
      ST_D_WRITE: begin
        // through the pointer or straight into the register
        bus.addr    = cmd.d_ptr ? addr_t'(dst_ptr) : d_addr;
        bus.wdata   = result;
        bus.write_q = 1'b1;
      end
      ST_S1_WB: begin
        bus.addr    = s1_addr;
        bus.wdata   = s1_wb;
        bus.write_q = 1'b1;
      end
      ST_S0_WB: begin
        bus.addr    = s0_addr;
        bus.wdata   = s0_wb;
        bus.write_q = 1'b1;
      end
      default: begin
        bus = '0;
      end
    endcase
  end

endmodule

// File: src/operand_file.sv
`timescale 1ns/1ps
`include "mm_consts.svh"

module operand_file (
  input  logic                clk,
  input  logic                rst,
  input  logic                read_dn,
  input  logic                alu_done,
  input  mm_pkg::fsm_state_t  state,
  input  mm_pkg::cmd_fields_t cmd,
  input  mm_pkg::data_t       data_in,
  input  mm_pkg::data_t       alu_result,
  output mm_pkg::data_t       src1,
  output mm_pkg::data_t       src0,
  output mm_pkg::data_t       s1_wb,
  output mm_pkg::data_t       s0_wb,
  output mm_pkg::data_t       dst_ptr,
  output mm_pkg::data_t       result
);
  import mm_pkg::*;

  // register contents as read, before any indirection
  data_t s1_val;
  data_t s0_val;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_val  <= '0;
      s0_val  <= '0;
      src1    <= '0;
      src0    <= '0;
      dst_ptr <= '0;
      result  <= '0;
    end else begin
      // register read fills both the raw value and the operand
      // pointer read then overwrites the operand only
      if ((state == ST_S1_REG) && read_dn) begin
        s1_val <= data_in;
        src1   <= data_in;
      end
      if ((state == ST_S1_PTR) && read_dn) src1 <= data_in;
      if ((state == ST_S0_REG) && read_dn) begin
        s0_val <= data_in;
        src0   <= data_in;
      end
      if ((state == ST_S0_PTR) && read_dn) src0 <= data_in;
      if ((state == ST_D_REG) && read_dn) dst_ptr <= data_in;
      // alu result taken on the same edge that leaves exec
      if ((state == ST_EXEC) && alu_done) result <= alu_result;
    end
  end

  // post-modify values
  assign s1_wb = (cmd.s1_flags == `MM_FLAG_INC) ? s1_val + data_t'(1) :
                 (cmd.s1_flags == `MM_FLAG_DEC) ? s1_val - data_t'(1) : s1_val;
  assign s0_wb = (cmd.s0_flags == `MM_FLAG_INC) ? s0_val + data_t'(1) :
                 (cmd.s0_flags == `MM_FLAG_DEC) ? s0_val - data_t'(1) : s0_val;

endmodule

// File: src/cmd_word_reg.sv
`timescale 1ns/1ps
`include "mm_consts.svh"

module cmd_word_reg (
  input  logic                clk,
  input  logic                rst,
  input  logic                read_dn,
  input  mm_pkg::fsm_state_t  state,
  input  mm_pkg::data_t       data_in,
  output mm_pkg::cmd_fields_t cmd
);
  import mm_pkg::*;

  data_t word;

  // latch the word on fetch completion
  always_ff @(posedge clk) begin
    if (rst) begin
      word <= '0;
    end else if ((state == ST_FETCH) && read_dn) begin
      word <= data_in;
    end
  end

  // field slicing
  assign cmd.s1_num   = word[`MM_S1_NUM_LSB +: `MM_REGNUM_W];
  assign cmd.s0_num   = word[`MM_S0_NUM_LSB +: `MM_REGNUM_W];
  assign cmd.d_num    = word[`MM_D_NUM_LSB +: `MM_REGNUM_W];
  assign cmd.s1_ptr   = word[`MM_S1_PTR_BIT];
  assign cmd.s0_ptr   = word[`MM_S0_PTR_BIT];
  assign cmd.d_ptr    = word[`MM_D_PTR_BIT];
  assign cmd.s1_flags = word[`MM_S1_FLAG_LSB +: `MM_FLAG_W];
  assign cmd.s0_flags = word[`MM_S0_FLAG_LSB +: `MM_FLAG_W];
  assign cmd.opcode   = word[`MM_OPCODE_LSB +: `MM_OPCODE_W];

endmodule

// File: src/ip_counter.sv
`timescale 1ns/1ps

module ip_counter (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  mm_pkg::fsm_state_t state,
  input  logic               read_dn,
  input  mm_pkg::addr_t      start_addr,
  output mm_pkg::addr_t      ip
);
  import mm_pkg::*;

  always_ff @(posedge clk) begin
    if (rst) begin
      ip <= '0;
    end else if ((state == ST_IDLE) && start) begin
      // new program position
      ip <= start_addr;
    end else if ((state == ST_FETCH) && read_dn) begin
      // step past the fetched word
      ip <= ip + addr_t'(1);
    end
  end

endmodule

// File: src/fetch_fsm.sv
`timescale 1ns/1ps
`include "mm_consts.svh"

module fetch_fsm (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  logic                read_dn,
  input  logic                write_dn,
  input  logic                alu_done,
  input  mm_pkg::cmd_fields_t cmd,
  output mm_pkg::fsm_state_t  state,
  output logic                operands_valid,
  output logic                done
);
  import mm_pkg::*;

  fsm_state_t state_next;
  logic       s1_wb_en;
  logic       s0_wb_en;

  // write-back only for the inc and dec codes
  assign s1_wb_en = (cmd.s1_flags == `MM_FLAG_INC) || (cmd.s1_flags == `MM_FLAG_DEC);
  assign s0_wb_en = (cmd.s0_flags == `MM_FLAG_INC) || (cmd.s0_flags == `MM_FLAG_DEC);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        // start only counts here
        if (start) state_next = ST_FETCH;
      end
      ST_FETCH: begin
        if (read_dn) state_next = ST_S1_REG;
      end
      ST_S1_REG: begin
        // cmd already holds the fetched word
        if (read_dn) state_next = cmd.s1_ptr ? ST_S1_PTR : ST_S0_REG;
      end
      ST_S1_PTR: begin
        if (read_dn) state_next = ST_S0_REG;
      end
      ST_S0_REG: begin
        if (read_dn) state_next = cmd.s0_ptr ? ST_S0_PTR : ST_EXEC;
      end
      ST_S0_PTR: begin
        if (read_dn) state_next = ST_EXEC;
      end
      ST_EXEC: begin
        // wait for the external alu
        if (alu_done) state_next = cmd.d_ptr ? ST_D_REG : ST_D_WRITE;
      end
      ST_D_REG: begin
        // dst register holds the target address
        if (read_dn) state_next = ST_D_WRITE;
      end
      ST_D_WRITE: begin
        if (write_dn) begin
          if (s1_wb_en) state_next = ST_S1_WB;
          else if (s0_wb_en) state_next = ST_S0_WB;
          else state_next = ST_DONE;
        end
      end
      ST_S1_WB: begin
        if (write_dn) state_next = s0_wb_en ? ST_S0_WB : ST_DONE;
      end
      ST_S0_WB: begin
        if (write_dn) state_next = ST_DONE;
      end
      ST_DONE: begin
        // single cycle marker
        state_next = ST_IDLE;
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  // both decoded straight from the state register
  assign operands_valid = (state == ST_EXEC);
  assign done = (state == ST_DONE);

endmodule

// File: src/mm_pkg.sv
`include "mm_consts.svh"

package mm_pkg;

  // vectors with a meaning of their own
  typedef logic [`MM_DATA_W-1:0]   data_t;
  typedef logic [`MM_ADDR_W-1:0]   addr_t;
  typedef logic [`MM_REGNUM_W-1:0] regnum_t;
  typedef logic [`MM_OPCODE_W-1:0] opcode_t;
  typedef logic [`MM_FLAG_W-1:0]   flag_t;

  // command word after decode
  typedef struct packed {
    opcode_t opcode;
    flag_t   s0_flags;
    flag_t   s1_flags;
    logic    d_ptr;
    logic    s0_ptr;
    logic    s1_ptr;
    regnum_t d_num;
    regnum_t s0_num;
    regnum_t s1_num;
  } cmd_fields_t;

  // request side of the memory bus
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    logic  read_q;
    logic  write_q;
  } bus_req_t;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_FETCH,
    ST_S1_REG,
    ST_S1_PTR,
    ST_S0_REG,
    ST_S0_PTR,
    ST_EXEC,
    ST_D_REG,
    ST_D_WRITE,
    ST_S1_WB,
    ST_S0_WB,
    ST_DONE
  } fsm_state_t;

endpackage

// File: src/mm_consts.svh
`ifndef MM_CONSTS_SVH
`define MM_CONSTS_SVH

// bus and register widths
`define MM_DATA_W      32
`define MM_ADDR_W      32
`define MM_REGNUM_W    4
`define MM_OPCODE_W    4
`define MM_FLAG_W      2

// lsb of each command word field
`define MM_S1_NUM_LSB  0
`define MM_S0_NUM_LSB  4
`define MM_D_NUM_LSB   8
`define MM_S1_PTR_BIT  16
`define MM_S0_PTR_BIT  17
`define MM_D_PTR_BIT   18
`define MM_S1_FLAG_LSB 20
`define MM_S0_FLAG_LSB 22
`define MM_OPCODE_LSB  28

// post-modify codes
// 00 and 11 leave the register alone
`define MM_FLAG_INC    2'b01
`define MM_FLAG_DEC    2'b10

`endif
